/* source/wb_config.svh */
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

`define WB_XLEN         32
`define WB_PC_RESET     32'h8000_0000
`define WB_UOP_W        5

// LSU micro-op fields, size sits in bits 2..1
`define WB_LSU_SIGNED   0
`define WB_LSU_LOAD     3
`define WB_LSU_STORE    4
`define WB_LSU_BYTE     2'b01
`define WB_LSU_HALF     2'b10
`define WB_LSU_WORD     2'b11

// CSR micro-op bits
`define WB_CSR_CLEAR    1
`define WB_CSR_SET      2
`define WB_CSR_WRITE    3
`define WB_CSR_READ     4

// Machine trap causes
`define WB_TRAP_BREAKPT  6'd3
`define WB_TRAP_LDACCESS 6'd5
`define WB_TRAP_STACCESS 6'd7
`define WB_TRAP_ECALLM   6'd11

`endif

/* source/wb_op_pkg.sv */
`include "wb_config.svh"

package wb_op_pkg;

    // Which unit finishes the instruction
    typedef enum logic [2:0] {
        FU_NONE = 3'd0,
        FU_EXEC = 3'd1,     // ALU, MUL, ASI, BIT
        FU_LSU  = 3'd2,
        FU_CFU  = 3'd3,
        FU_CSR  = 3'd4
    } fu_t;

    // Control flow micro-ops, same width as uop
    typedef enum logic [`WB_UOP_W-1:0] {
        CFU_NOT_TAKEN = 5'd0,
        CFU_TAKEN     = 5'd1,
        CFU_JALI      = 5'd2,
        CFU_JALR      = 5'd3,
        CFU_EBREAK    = 5'd4,
        CFU_ECALL     = 5'd5,
        CFU_MRET      = 5'd6
    } cfu_uop_t;

    // One CSR file access
    typedef struct packed {
        logic                  en;
        logic                  wr;
        logic                  set;
        logic                  clr;
        logic [11:0]           addr;
        logic [`WB_XLEN-1:0]   wdata;
    } csr_req_t;

endpackage

/* source/wb_data_pkg.sv */
`include "wb_config.svh"

package wb_data_pkg;

    typedef logic [`WB_XLEN-1:0]  xlen_t;
    typedef logic [4:0]           reg_addr_t;
    typedef logic [11:0]          csr_addr_t;
    typedef logic [5:0]           cause_t;
    typedef logic [`WB_UOP_W-1:0] uop_t;

    // Instruction as handed over by the memory stage
    typedef struct packed {
        reg_addr_t       rd;
        xlen_t           opr_a;
        xlen_t           opr_b;     // Load/store address
        uop_t            uop;
        wb_op_pkg::fu_t  fu;
        logic            trap;      // Trap raised further up
        logic [1:0]      size;      // In halfwords
    } stage_in_t;

    typedef struct packed {
        logic       wen;
        reg_addr_t  rd;
        xlen_t      wdata;
    } gpr_wr_t;

    typedef struct packed {
        logic   recv;
        logic   error;
        xlen_t  rdata;
    } dmem_rsp_t;

    typedef struct packed {
        logic    cpu;     // Exception or trapping instruction
        logic    intr;    // Interrupt taken
        cause_t  cause;
        xlen_t   pc;
    } trap_info_t;

endpackage

/* source/wb_load_unit.sv */
`include "wb_config.svh"

module wb_load_unit (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_data_pkg::stage_in_t  stage,
    input  logic                    pipe_progress,
    input  wb_data_pkg::dmem_rsp_t  dmem_rsp,
    output logic                    dmem_ack,
    output logic                    lsu_busy,
    output logic                    lsu_trap,
    output logic                    lsu_store,
    output logic                    rsp_expected,
    output wb_data_pkg::gpr_wr_t    gpr_wr
);

    logic               fu_lsu;
    logic               lsu_load;
    logic               lsu_signed;
    logic [1:0]         lsu_size;
    logic               rsp_seen;       // Response already taken
    logic               err_seen;       // Error kept until retire
    logic               rsp_take;
    logic               bus_err;
    logic [3:0]         strb;
    wb_data_pkg::xlen_t lane_mask;
    wb_data_pkg::xlen_t lane_data;
    wb_data_pkg::xlen_t shifted;
    wb_data_pkg::xlen_t load_data;

    // Decode ----------------------------------
    assign fu_lsu     = stage.fu == wb_op_pkg::FU_LSU;
    assign lsu_load   = fu_lsu && stage.uop[`WB_LSU_LOAD];
    assign lsu_store  = fu_lsu && stage.uop[`WB_LSU_STORE];
    assign lsu_signed = stage.uop[`WB_LSU_SIGNED];
    assign lsu_size   = stage.uop[2:1];
    assign strb       = stage.opr_a[3:0];   // Byte strobes from mem stage

    // Response tracking -----------------------
    assign rsp_expected = fu_lsu && !rsp_seen;
    assign dmem_ack     = rsp_expected;     // Only ack when one is due
    assign rsp_take     = dmem_rsp.recv && dmem_ack;
    assign bus_err      = rsp_take && dmem_rsp.error;
    assign lsu_trap     = bus_err || err_seen;
    assign lsu_busy     = fu_lsu && !(rsp_seen || rsp_take);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_seen <= 1'b0;
            err_seen <= 1'b0;
        end else begin
            rsp_seen <= !pipe_progress && (rsp_seen || rsp_take);
            err_seen <= !pipe_progress && lsu_trap;   // Hold cf request steady
        end
    end

    // Data alignment --------------------------
    assign lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    assign lane_data = dmem_rsp.rdata & lane_mask;
    assign shifted   = lane_data >> {stage.opr_b[1:0], 3'b000};  // Lane down to bit 0

    always_comb begin
        case (lsu_size)
            `WB_LSU_BYTE: load_data = {{24{lsu_signed && shifted[7]}}, shifted[7:0]};
            `WB_LSU_HALF: load_data = {{16{lsu_signed && shifted[15]}}, shifted[15:0]};
            default:      load_data = shifted;   // Word
        endcase
    end

    // Single write in the accepted cycle, none on error
    assign gpr_wr.wen   = lsu_load && rsp_take && !dmem_rsp.error;
    assign gpr_wr.rd    = stage.rd;
    assign gpr_wr.wdata = load_data;

endmodule

/* source/wb_flow_unit.sv */
`include "wb_config.svh"

module wb_flow_unit (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_data_pkg::stage_in_t  stage,
    input  logic                    s4_valid,
    input  logic                    pipe_progress,
    input  logic                    lsu_trap,
    input  logic                    lsu_store,
    input  logic                    rsp_expected,
    input  logic                    lsu_busy,
    input  logic                    cf_ack,
    input  wb_data_pkg::xlen_t      csr_mepc,
    input  wb_data_pkg::xlen_t      csr_mtvec,
    input  logic                    int_trap_req,
    input  wb_data_pkg::cause_t     int_trap_cause,
    output logic                    cf_req,
    output wb_data_pkg::xlen_t      cf_target,
    output logic                    cfu_busy,
    output logic                    exec_mret,
    output logic                    hold_lsu_req,
    output wb_data_pkg::trap_info_t trap,
    output wb_data_pkg::gpr_wr_t    gpr_wr
);

    wb_data_pkg::xlen_t  pc;
    wb_data_pkg::xlen_t  pc_step;
    wb_data_pkg::xlen_t  pc_next;
    wb_op_pkg::cfu_uop_t cfu_op;
    logic fu_cfu;
    logic cfu_taken;
    logic cfu_link;
    logic cfu_ebreak;
    logic cfu_ecall;
    logic cfu_mret;
    logic cfu_trap;
    logic s4_trap;
    logic trap_cpu;
    logic trap_int;
    logic tgt_trap;
    logic cf_any;
    logic cfu_done;       // Request acked, instruction still here
    logic int_pending;    // Interrupt seen while stalled

    // Decode ----------------------------------
    assign cfu_op     = wb_op_pkg::cfu_uop_t'(stage.uop);
    assign fu_cfu     = stage.fu == wb_op_pkg::FU_CFU;
    assign cfu_link   = fu_cfu && (cfu_op == wb_op_pkg::CFU_JALI ||
                                   cfu_op == wb_op_pkg::CFU_JALR);
    assign cfu_taken  = cfu_link || (fu_cfu && cfu_op == wb_op_pkg::CFU_TAKEN);
    assign cfu_ebreak = fu_cfu && cfu_op == wb_op_pkg::CFU_EBREAK;
    assign cfu_ecall  = fu_cfu && cfu_op == wb_op_pkg::CFU_ECALL;
    assign cfu_mret   = fu_cfu && cfu_op == wb_op_pkg::CFU_MRET;
    assign cfu_trap   = cfu_ebreak || cfu_ecall;
    assign s4_trap    = s4_valid && stage.trap;

    // Trap sources ----------------------------
    assign trap_cpu = cfu_trap || lsu_trap || s4_trap;
    // Interrupt loses to a CPU trap and waits out a pending response
    assign trap_int = s4_valid && (int_trap_req || int_pending) &&
                      !trap_cpu && !rsp_expected;
    assign tgt_trap = trap_cpu || trap_int;

    // Flow request ----------------------------
    assign cf_any    = cfu_taken || cfu_mret || tgt_trap;
    assign cf_req    = cf_any && !cfu_done;
    assign cfu_busy  = cf_req && !cf_ack;
    assign cf_target = tgt_trap ? csr_mtvec :
                       cfu_mret ? csr_mepc  :
                                  stage.opr_a;   // Branch/jump target

    assign exec_mret    = cfu_mret && pipe_progress;   // Pulse on retire
    assign hold_lsu_req = cf_req || lsu_busy || trap_int;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done    <= 1'b0;
            int_pending <= 1'b0;
        end else begin
            cfu_done <= !pipe_progress && (cfu_done || (cf_req && cf_ack));
            if (int_pending) begin
                int_pending <= !(trap_int && cf_req && cf_ack);
            end else begin
                int_pending <= int_trap_req && !pipe_progress;
            end
        end
    end

    // PC tracking -----------------------------
    assign pc_step = wb_data_pkg::xlen_t'({stage.size, 1'b0});  // Size in bytes
    assign pc_next = pc + pc_step;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= `WB_PC_RESET;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target;
        end else if (pipe_progress) begin
            pc <= pc_next;
        end
    end

    // Trap report
    assign trap.cpu   = trap_cpu;
    assign trap.intr  = trap_int;
    assign trap.pc    = pc;
    assign trap.cause = lsu_trap && !lsu_store ? `WB_TRAP_LDACCESS :
                        lsu_trap               ? `WB_TRAP_STACCESS :
                        cfu_ebreak             ? `WB_TRAP_BREAKPT  :
                        cfu_ecall              ? `WB_TRAP_ECALLM   :
                        trap_int               ? int_trap_cause    :
                                                 stage.opr_a[5:0];

    // Link register gets the fall-through PC
    assign gpr_wr.wen   = cfu_link && !cfu_done;
    assign gpr_wr.rd    = stage.rd;
    assign gpr_wr.wdata = pc_next;

endmodule

/* source/wb_csr_unit.sv */
`include "wb_config.svh"

module wb_csr_unit (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_data_pkg::stage_in_t  stage,
    input  logic                    pipe_progress,
    input  wb_data_pkg::xlen_t      csr_rdata,
    output wb_op_pkg::csr_req_t     csr_req,
    output wb_data_pkg::gpr_wr_t    gpr_wr
);

    logic                   fu_csr;
    logic                   csr_done;   // Access already made
    wb_data_pkg::csr_addr_t csr_addr;

    assign fu_csr   = stage.fu == wb_op_pkg::FU_CSR;
    assign csr_addr = stage.opr_b[11:0];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
        end else begin
            csr_done <= !pipe_progress && (csr_done || csr_req.en);
        end
    end

    assign csr_req.en    = fu_csr && !csr_done;     // One cycle per instruction
    assign csr_req.wr    = fu_csr && stage.uop[`WB_CSR_WRITE];
    assign csr_req.set   = fu_csr && stage.uop[`WB_CSR_SET];
    assign csr_req.clr   = fu_csr && stage.uop[`WB_CSR_CLEAR];
    assign csr_req.addr  = csr_addr;
    assign csr_req.wdata = stage.opr_a;

    assign gpr_wr.wen   = csr_req.en && stage.uop[`WB_CSR_READ];  // Old value to rd
    assign gpr_wr.rd    = stage.rd;
    assign gpr_wr.wdata = csr_rdata;

endmodule

/* source/wb_retire_ctrl.sv */
module wb_retire_ctrl (
    input  wb_data_pkg::stage_in_t  stage,
    input  logic                    s4_valid,
    input  logic                    lsu_busy,
    input  logic                    cfu_busy,
    input  wb_data_pkg::gpr_wr_t    load_wr,
    input  wb_data_pkg::gpr_wr_t    flow_wr,
    input  wb_data_pkg::gpr_wr_t    csr_wr_req,
    output logic                    s4_busy,
    output logic                    pipe_progress,
    output wb_data_pkg::gpr_wr_t    gpr_wr
);

    wb_data_pkg::gpr_wr_t exec_wr;
    wb_data_pkg::gpr_wr_t reqs [4];
    logic                 any_wen;

    // Exec class result already sits in operand A
    assign exec_wr.wen   = stage.fu == wb_op_pkg::FU_EXEC;
    assign exec_wr.rd    = stage.rd;
    assign exec_wr.wdata = stage.opr_a;

    assign reqs[0] = exec_wr;
    assign reqs[1] = load_wr;
    assign reqs[2] = flow_wr;
    assign reqs[3] = csr_wr_req;

    // Exclusive by decode, plain OR merge
    always_comb begin
        any_wen      = 1'b0;
        gpr_wr.rd    = '0;
        gpr_wr.wdata = '0;
        for (int i = 0; i < 4; i++) begin
            if (reqs[i].wen) begin
                any_wen      = 1'b1;
                gpr_wr.rd    = gpr_wr.rd | reqs[i].rd;
                gpr_wr.wdata = gpr_wr.wdata | reqs[i].wdata;
            end
        end
        gpr_wr.wen = s4_valid && !stage.trap && any_wen;  // Trapped op writes nothing
    end

    assign s4_busy       = lsu_busy || cfu_busy;
    assign pipe_progress = s4_valid && !s4_busy;

endmodule

/* source/wb_stage.sv */
module wb_stage (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  wb_data_pkg::stage_in_t  stage,
    input  logic                    s4_valid,
    output logic                    s4_busy,
    input  wb_data_pkg::dmem_rsp_t  dmem_rsp,
    output logic                    dmem_ack,
    output logic                    cf_req,
    output wb_data_pkg::xlen_t      cf_target,
    input  logic                    cf_ack,
    output wb_op_pkg::csr_req_t     csr_req,
    input  wb_data_pkg::xlen_t      csr_rdata,
    input  wb_data_pkg::xlen_t      csr_mepc,
    input  wb_data_pkg::xlen_t      csr_mtvec,
    input  logic                    int_trap_req,
    input  wb_data_pkg::cause_t     int_trap_cause,
    output wb_data_pkg::gpr_wr_t    gpr_wr,
    output wb_data_pkg::trap_info_t trap,
    output logic                    exec_mret,
    output logic                    hold_lsu_req
);

    logic                 pipe_progress;
    logic                 lsu_busy;
    logic                 cfu_busy;
    logic                 lsu_trap;
    logic                 lsu_store;
    logic                 rsp_expected;
    wb_data_pkg::gpr_wr_t load_wr;
    wb_data_pkg::gpr_wr_t flow_wr;
    wb_data_pkg::gpr_wr_t csr_wr;

    // Units ------------------------------------
    wb_load_unit i_load (
        .g_clk, .g_resetn, .stage, .pipe_progress, .dmem_rsp, .dmem_ack,
        .lsu_busy, .lsu_trap, .lsu_store, .rsp_expected, .gpr_wr(load_wr)
    );

    wb_flow_unit i_flow (
        .g_clk, .g_resetn, .stage, .s4_valid, .pipe_progress, .lsu_trap,
        .lsu_store, .rsp_expected, .lsu_busy, .cf_ack, .csr_mepc, .csr_mtvec,
        .int_trap_req, .int_trap_cause, .cf_req, .cf_target, .cfu_busy,
        .exec_mret, .hold_lsu_req, .trap, .gpr_wr(flow_wr)
    );

    wb_csr_unit i_csr (
        .g_clk, .g_resetn, .stage, .pipe_progress, .csr_rdata, .csr_req,
        .gpr_wr(csr_wr)
    );

    // Write merge and stall
    wb_retire_ctrl i_retire (
        .stage, .s4_valid, .lsu_busy, .cfu_busy, .load_wr, .flow_wr,
        .csr_wr_req(csr_wr), .s4_busy, .pipe_progress, .gpr_wr
    );

endmodule

/* verification/wb_stage_tb.sv */
`include "wb_config.svh"

module wb_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_LOADS     = 12;
    localparam int N_INSTR     = 28;
    localparam int CYCLE_LIMIT = 40 * N_INSTR + 10;   // Plus reset cycles

    // Expected outcome of one instruction
    typedef struct packed {
        wb_data_pkg::gpr_wr_t      wr;
        logic                      cf;
        wb_data_pkg::xlen_t        target;
        wb_data_pkg::trap_info_t   trap;
        logic                      mret;
    } expect_t;

    logic                    g_clk;
    logic                    g_resetn;
    wb_data_pkg::stage_in_t  stage;
    logic                    s4_valid;
    logic                    s4_busy;
    wb_data_pkg::dmem_rsp_t  dmem_rsp;
    logic                    dmem_ack;
    logic                    cf_req;
    wb_data_pkg::xlen_t      cf_target;
    logic                    cf_ack;
    wb_op_pkg::csr_req_t     csr_req;
    wb_data_pkg::xlen_t      csr_rdata;
    wb_data_pkg::xlen_t      csr_mepc;
    wb_data_pkg::xlen_t      csr_mtvec;
    logic                    int_trap_req;
    wb_data_pkg::cause_t     int_trap_cause;
    wb_data_pkg::gpr_wr_t    gpr_wr;
    wb_data_pkg::trap_info_t trap;
    logic                    exec_mret;
    logic                    hold_lsu_req;

    integer                  seed = 32'h16f7_cdad;
    int                      cycle_count = 0;
    int                      error_count = 0;
    int                      wr_cnt = 0;      // Writes seen for current op
    int                      csr_cnt = 0;
    logic                    cf_seen = 1'b0;
    logic                    rsp_done = 1'b0; // Memory response already delivered
    logic                    ack_due;         // Response still owed
    logic                    busy_due;
    logic                    hold_due;
    wb_data_pkg::xlen_t      model_pc;        // PC as the testbench tracks it
    expect_t                 exp;
    wb_op_pkg::csr_req_t     exp_csr;
    logic                    exp_once;        // Write allowed only once

    wb_stage i_dut (.*);

    always #10 g_clk = ~g_clk;

    // Error handling ------------------------
    task automatic fail_run(string msg);
        error_count++;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_gpr(wb_data_pkg::gpr_wr_t got, wb_data_pkg::gpr_wr_t want);
        if (got !== want) fail_run($sformatf("MISMATCH gpr_wr got %h expected %h", got, want));
    endtask

    task automatic check_flow(string name, wb_data_pkg::xlen_t got, wb_data_pkg::xlen_t want);
        if (got !== want) fail_run($sformatf("MISMATCH %s got %h expected %h", name, got, want));
    endtask

    task automatic check_trap(wb_data_pkg::trap_info_t got, wb_data_pkg::trap_info_t want);
        if (got !== want) fail_run($sformatf("MISMATCH trap got %h expected %h", got, want));
    endtask

    task automatic check_csr(wb_op_pkg::csr_req_t got, wb_op_pkg::csr_req_t want);
        if (got !== want) fail_run($sformatf("MISMATCH csr_req got %h expected %h", got, want));
    endtask

    // Reference model ---------------------------
    function automatic wb_data_pkg::xlen_t next_random();
        return $random(seed);
    endfunction

    // Byte by byte pick, then extend
    function automatic wb_data_pkg::xlen_t load_value(wb_data_pkg::xlen_t rdata, int addr,
                                                      logic [1:0] size, logic sgn);
        wb_data_pkg::xlen_t v;
        int                 nbytes;
        nbytes = size == `WB_LSU_BYTE ? 1 : size == `WB_LSU_HALF ? 2 : 4;
        v      = '0;
        for (int i = 0; i < nbytes; i++) v[i*8 +: 8] = rdata[(addr + i)*8 +: 8];
        if (sgn && nbytes < 4 && v[nbytes*8-1]) begin
            for (int i = nbytes * 8; i < 32; i++) v[i] = 1'b1;
        end
        return v;
    endfunction

    function automatic expect_t ref_result(wb_data_pkg::stage_in_t s, wb_data_pkg::xlen_t rdata,
                                           logic err, wb_data_pkg::xlen_t pc, logic irq);
        expect_t e;
        e            = '0;
        e.wr.rd      = s.rd;
        e.trap.pc    = pc;
        e.trap.cause = s.opr_a[5:0];        // Fallback cause
        case (s.fu)
            wb_op_pkg::FU_EXEC: begin
                e.wr.wen   = 1'b1;
                e.wr.wdata = s.opr_a;
            end
            wb_op_pkg::FU_LSU: begin
                if (err) begin
                    e.trap.cpu   = 1'b1;
                    e.trap.cause = s.uop[`WB_LSU_STORE] ? `WB_TRAP_STACCESS : `WB_TRAP_LDACCESS;
                end else if (s.uop[`WB_LSU_LOAD]) begin
                    e.wr.wen   = 1'b1;
                    e.wr.wdata = load_value(rdata, int'(s.opr_b[1:0]), s.uop[2:1],
                                            s.uop[`WB_LSU_SIGNED]);
                end
            end
            wb_op_pkg::FU_CFU: begin
                case (wb_op_pkg::cfu_uop_t'(s.uop))
                    wb_op_pkg::CFU_TAKEN: begin
                        e.cf     = 1'b1;
                        e.target = s.opr_a;
                    end
                    wb_op_pkg::CFU_JALI, wb_op_pkg::CFU_JALR: begin
                        e.cf       = 1'b1;
                        e.target   = s.opr_a;
                        e.wr.wen   = 1'b1;
                        e.wr.wdata = pc + 32'(s.size) * 2;   // Link is fall-through PC
                    end
                    wb_op_pkg::CFU_EBREAK: begin
                        e.trap.cpu   = 1'b1;
                        e.trap.cause = `WB_TRAP_BREAKPT;
                    end
                    wb_op_pkg::CFU_ECALL: begin
                        e.trap.cpu   = 1'b1;
                        e.trap.cause = `WB_TRAP_ECALLM;
                    end
                    wb_op_pkg::CFU_MRET: begin
                        e.cf     = 1'b1;
                        e.target = csr_mepc;
                        e.mret   = 1'b1;
                    end
                    default: ;
                endcase
            end
            wb_op_pkg::FU_CSR: begin
                e.wr.wen   = s.uop[`WB_CSR_READ];
                e.wr.wdata = csr_rdata;
            end
            default: ;
        endcase
        if (s.trap) begin
            e.trap.cpu = 1'b1;                  // Upstream trap suppresses the write
            e.wr.wen   = 1'b0;
        end
        if (!e.trap.cpu && irq) begin
            e.trap.intr  = 1'b1;
            e.trap.cause = int_trap_cause;
        end
        if (e.trap.cpu || e.trap.intr) begin
            e.cf     = 1'b1;
            e.target = csr_mtvec;
        end
        return e;
    endfunction

    function automatic wb_op_pkg::csr_req_t ref_csr(wb_data_pkg::stage_in_t s);
        wb_op_pkg::csr_req_t c;
        c       = '0;
        c.en    = s.fu == wb_op_pkg::FU_CSR;
        c.wr    = c.en && s.uop[`WB_CSR_WRITE];
        c.set   = c.en && s.uop[`WB_CSR_SET];
        c.clr   = c.en && s.uop[`WB_CSR_CLEAR];
        c.addr  = s.opr_b[11:0];
        c.wdata = s.opr_a;
        return c;
    endfunction

    function automatic wb_data_pkg::stage_in_t build_instr(wb_op_pkg::fu_t fu,
            wb_data_pkg::uop_t uop, wb_data_pkg::xlen_t a, wb_data_pkg::xlen_t b,
            wb_data_pkg::reg_addr_t rd, logic trap_in);
        wb_data_pkg::stage_in_t s;
        s.rd    = rd;
        s.opr_a = a;
        s.opr_b = b;
        s.uop   = uop;
        s.fu    = fu;
        s.trap  = trap_in;
        s.size  = 2'd2;                         // Always a 4 byte instruction
        return s;
    endfunction

    // Stimulus ------------------------------------
    // Drives one instruction, models memory and cf_ack, waits for retire
    task automatic issue(wb_data_pkg::stage_in_t s, wb_data_pkg::xlen_t rdata, logic err,
                         logic irq);
        int cyc;
        int mem_dly;
        int ack_dly;
        logic is_lsu;
        mem_dly        = int'($unsigned(next_random()) % 4);
        ack_dly        = int'($unsigned(next_random()) % 4);
        is_lsu         = s.fu == wb_op_pkg::FU_LSU;
        exp            = ref_result(s, rdata, err, model_pc, irq);
        exp_csr        = ref_csr(s);
        exp_once       = s.fu == wb_op_pkg::FU_LSU || s.fu == wb_op_pkg::FU_CSR;
        stage          = s;
        s4_valid       = 1'b1;
        int_trap_req   = irq;
        dmem_rsp.rdata = rdata;
        dmem_rsp.error = err;
        cyc            = 0;
        dmem_rsp.recv  = is_lsu && mem_dly == 0;
        cf_ack         = ack_dly == 0;
        forever begin
            @(negedge g_clk);
            if (!s4_busy) break;
            @(posedge g_clk);
            #2;
            cyc++;
            dmem_rsp.recv = is_lsu && cyc >= mem_dly;   // Late response
            cf_ack        = cyc >= ack_dly;
        end
        @(posedge g_clk);
        model_pc = exp.cf ? exp.target : model_pc + 32'(s.size) * 2;
        #2;
        s4_valid      = 1'b0;
        stage.fu      = wb_op_pkg::FU_NONE;
        dmem_rsp.recv = 1'b0;
        cf_ack        = 1'b0;
        int_trap_req  = 1'b0;
    endtask

    task automatic run_load(logic [1:0] size, logic err, logic store);
        logic [1:0]         addr;
        logic [3:0]         strb;
        wb_data_pkg::xlen_t r;
        r    = next_random();
        addr = size == `WB_LSU_BYTE ? r[1:0] : size == `WB_LSU_HALF ? {r[1], 1'b0} : 2'b00;
        strb = size == `WB_LSU_BYTE ? 4'b0001 << addr :
               size == `WB_LSU_HALF ? 4'b0011 << addr : 4'b1111;
        issue(build_instr(wb_op_pkg::FU_LSU, {store, !store, size, r[8]},
                          {r[31:4], strb}, {next_random() & ~32'h3 | 32'(addr)},
                          r[16:12], 1'b0), next_random(), err, 1'b0);
    endtask

    // Comparing process ---------------------------
    always @(negedge g_clk) begin
        if (g_resetn && s4_valid) begin
            ack_due  = stage.fu == wb_op_pkg::FU_LSU && !rsp_done;
            busy_due = (ack_due && !dmem_rsp.recv) || (exp.cf && !cf_ack);
            hold_due = (ack_due && !dmem_rsp.recv) || exp.cf;   // Flow change or load pending
            check_flow("trap.pc", trap.pc, exp.trap.pc);
            if (dmem_ack !== ack_due)
                fail_run($sformatf("MISMATCH dmem_ack got %h expected %h", dmem_ack, ack_due));
            if (s4_busy !== busy_due)
                fail_run($sformatf("MISMATCH s4_busy got %h expected %h", s4_busy, busy_due));
            if (hold_lsu_req !== hold_due)
                fail_run($sformatf("MISMATCH hold_lsu_req got %h expected %h",
                                   hold_lsu_req, hold_due));
            if (exec_mret !== (exp.mret && !busy_due))
                fail_run($sformatf("MISMATCH exec_mret got %h expected %h",
                                   exec_mret, exp.mret && !busy_due));
            if (gpr_wr.wen) begin
                wr_cnt++;
                check_gpr(gpr_wr, exp.wr);
                if (stage.fu == wb_op_pkg::FU_LSU && !(ack_due && dmem_rsp.recv))
                    fail_run("Load write outside its response cycle");
            end
            if (cf_req) begin
                cf_seen = 1'b1;
                check_flow("cf_target", cf_target, exp.target);
                check_trap(trap, exp.trap);
            end
            if (csr_req.en) begin
                csr_cnt++;
                check_csr(csr_req, exp_csr);
            end
            if (ack_due && dmem_rsp.recv) rsp_done = 1'b1;
            if (!s4_busy) begin                 // Retire cycle
                if (cf_seen != exp.cf) fail_run("Control flow request missing or unexpected");
                if (exp.wr.wen && wr_cnt == 0) fail_run("Expected register write never came");
                if (exp_once && wr_cnt > 1) fail_run("Register write repeated");
                if (exp_csr.en && csr_cnt != 1) fail_run("CSR access not exactly one cycle");
                wr_cnt   = 0;
                csr_cnt  = 0;
                cf_seen  = 1'b0;
                rsp_done = 1'b0;
            end
        end else if (g_resetn) begin
            if ({cf_req, csr_req.en, gpr_wr.wen} !== 3'b000)
                fail_run("Request raised while the stage is empty");
        end
    end

    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) fail_run("Timeout, DUT stopped retiring instructions");
    end

    initial begin
        g_clk          = 1'b0;
        g_resetn       = 1'b0;
        stage          = '0;
        s4_valid       = 1'b0;
        dmem_rsp       = '0;
        cf_ack         = 1'b0;
        csr_rdata      = 32'hc5a0_1234;
        csr_mepc       = 32'h8000_0444;
        csr_mtvec      = 32'h8000_0800;
        int_trap_req   = 1'b0;
        int_trap_cause = 6'h2b;
        model_pc       = `WB_PC_RESET;
        exp            = '0;
        exp_csr        = '0;
        exp_once       = 1'b0;
        repeat (10) @(posedge g_clk);
        #2 g_resetn = 1'b1;

        // Exec, then with upstream trap
        issue(build_instr(wb_op_pkg::FU_EXEC, '0, next_random(), '0, 5'd3, 1'b0), '0, 0, 0);
        issue(build_instr(wb_op_pkg::FU_EXEC, '0, next_random(), '0, 5'd4, 1'b1), '0, 0, 0);

        // Random loads, store, bus errors
        for (int i = 0; i < N_LOADS; i++) begin
            run_load(2'(($unsigned(next_random()) % 3) + 1), 1'b0, 1'b0);
        end
        run_load(`WB_LSU_WORD, 1'b0, 1'b1);
        run_load(`WB_LSU_HALF, 1'b1, 1'b0);
        run_load(`WB_LSU_WORD, 1'b1, 1'b1);

        // Branch, jumps, then an exec at the new PC
        issue(build_instr(wb_op_pkg::FU_CFU, wb_op_pkg::CFU_TAKEN, 32'h8000_0100, '0,
                          5'd0, 1'b0), '0, 0, 0);
        issue(build_instr(wb_op_pkg::FU_CFU, wb_op_pkg::CFU_JALI, 32'h8000_0200, '0,
                          5'd1, 1'b0), '0, 0, 0);
        issue(build_instr(wb_op_pkg::FU_CFU, wb_op_pkg::CFU_JALR, 32'h8000_0310, '0,
                          5'd5, 1'b0), '0, 0, 0);
        issue(build_instr(wb_op_pkg::FU_EXEC, '0, next_random(), '0, 5'd7, 1'b0), '0, 0, 0);

        // Traps and return
        issue(build_instr(wb_op_pkg::FU_CFU, wb_op_pkg::CFU_EBREAK, '0, '0, 5'd0, 1'b0),
              '0, 0, 0);
        issue(build_instr(wb_op_pkg::FU_CFU, wb_op_pkg::CFU_ECALL, '0, '0, 5'd0, 1'b0),
              '0, 0, 0);
        issue(build_instr(wb_op_pkg::FU_CFU, wb_op_pkg::CFU_MRET, '0, '0, 5'd0, 1'b0),
              '0, 0, 0);

        // CSR read-write, then set and clear without read
        issue(build_instr(wb_op_pkg::FU_CSR, 5'b11000, next_random(), 32'h300, 5'd9, 1'b0),
              '0, 0, 0);
        issue(build_instr(wb_op_pkg::FU_CSR, 5'b00110, next_random(), 32'h344, 5'd9, 1'b0),
              '0, 0, 0);

        // Interrupt on an exec op
        issue(build_instr(wb_op_pkg::FU_EXEC, '0, next_random(), '0, 5'd11, 1'b0), '0, 0, 1);
        issue(build_instr(wb_op_pkg::FU_EXEC, '0, next_random(), '0, 5'd12, 1'b0), '0, 0, 0);

        repeat (2) @(posedge g_clk);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* wb_stage.f */
+incdir+source
source/wb_op_pkg.sv
source/wb_data_pkg.sv
source/wb_load_unit.sv
source/wb_flow_unit.sv
source/wb_csr_unit.sv
source/wb_retire_ctrl.sv
source/wb_stage.sv
verification/wb_stage_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := wb_stage_tb
FILELIST   := wb_stage.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation FAILED" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
